// ==== compile.f ====
hw/z80_pkg.sv
hw/shared_ram.sv
hw/mem_arbiter.sv
hw/video_fetch.sv
hw/z80_core.sv
hw/z80_system.sv
test/tb_z80_system.sv

// ==== test/tb_z80_system.sv ====
`timescale 1ns/1ps

module tb_z80_system;

    localparam int             mem_aw       = 10;
    localparam z80_pkg::addr_t video_base   = 16'h0300;
    localparam int             video_len    = 32;
    localparam int             video_period = 5;
    localparam int             n_rounds     = 3;
    localparam int             n_items      = 12;     // Program items before HALT
    localparam int             clk_period   = 4;

    logic              clk_z80, rst_n, load_en, video_en;
    logic [mem_aw-1:0] load_addr;
    z80_pkg::byte_t    load_data, reg_a, reg_f, reg_b, video_data;
    z80_pkg::addr_t    pc;
    logic              iff1, halted, video_valid;

    integer            seed;
    int                vid_idx;                       // Next offset in display region
    int                wr_ptr;                        // Program build pointer
    z80_pkg::byte_t    img [2**mem_aw];               // Reference memory image
    z80_pkg::addr_t    halt_addr;
    z80_pkg::byte_t    exp_a, exp_f, exp_b;           // Model results
    logic              exp_iff1;

    z80_system #(
        .mem_aw(mem_aw), .video_base(video_base), .video_len(video_len),
        .video_period(video_period), .sp_init(16'hdff0)
    ) z80_system_inst (
        .clk_z80(clk_z80), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .video_en(video_en), .reg_a(reg_a), .reg_f(reg_f),
        .reg_b(reg_b), .pc(pc), .iff1(iff1), .halted(halted),
        .video_data(video_data), .video_valid(video_valid)
    );

    initial clk_z80 = 1'b0;
    always #(clk_period / 2) clk_z80 = ~clk_z80;

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // ------------------------------------------------------------------
    // Program generation and reference model
    // ------------------------------------------------------------------

    task automatic emit(input z80_pkg::byte_t b);
        img[wr_ptr] = b;
        wr_ptr++;
    endtask

    task automatic build_program();
        int kind;
        int n;
        for (int i = 0; i < 2**mem_aw; i++)
            img[i] = z80_pkg::byte_t'($random(seed));   // Random background
        wr_ptr = 0;
        for (int i = 0; i < n_items; i++) begin
            kind = $unsigned($random(seed)) % 8;
            n    = $unsigned($random(seed)) % 4;
            case (kind)
                0: emit(z80_pkg::op_nop);
                1: emit(z80_pkg::op_ex_af);
                2: emit(z80_pkg::op_di);
                3: emit(z80_pkg::op_ei);
                4: begin
                    emit(z80_pkg::op_ld_a_n);
                    emit(z80_pkg::byte_t'($random(seed)));
                end
                5: begin
                    emit(z80_pkg::op_ld_b_n);
                    emit(z80_pkg::byte_t'($random(seed)));
                end
                6: begin                                 // Forward JR over NOPs
                    emit(z80_pkg::op_jr);
                    emit(z80_pkg::byte_t'(n));
                    repeat (n) emit(z80_pkg::op_nop);
                end
                default: begin                           // LD B,n then NOP/DJNZ loop
                    emit(z80_pkg::op_ld_b_n);
                    emit(z80_pkg::byte_t'(n + 1));
                    emit(z80_pkg::op_nop);
                    emit(z80_pkg::op_djnz);
                    emit(8'hFD);                         // Back to the NOP
                end
            endcase
        end
        halt_addr = z80_pkg::addr_t'(wr_ptr);
        emit(z80_pkg::op_halt);
    endtask

    task automatic run_model();
        z80_pkg::addr_t mpc;
        z80_pkg::byte_t op, opnd, a_alt, f_alt, tmp;
        logic pend_di, pend_ei, late_di, late_ei;
        int steps;
        mpc = 16'h0000;
        exp_a = 8'h01;
        exp_f = 8'h05;
        exp_b = 8'h00;
        a_alt = 8'h02;
        f_alt = 8'h04;
        exp_iff1 = 1'b0;
        {pend_di, pend_ei, late_di, late_ei} = 4'b0;
        op = z80_pkg::op_nop;
        steps = 0;
        while (op != z80_pkg::op_halt && steps < 5000) begin
            op   = img[mpc[mem_aw-1:0]];
            mpc  = mpc + 16'd1;
            opnd = img[mpc[mem_aw-1:0]];
            // DI/EI from two instructions back lands at this fetch
            if (late_di)
                exp_iff1 = 1'b0;
            else if (late_ei)
                exp_iff1 = 1'b1;
            late_di = pend_di;
            late_ei = pend_ei;
            pend_di = 1'b0;
            pend_ei = 1'b0;
            case (op)
                z80_pkg::op_di:     pend_di = 1'b1;
                z80_pkg::op_ei:     pend_ei = 1'b1;
                z80_pkg::op_ld_a_n: begin
                    exp_a = opnd;
                    mpc   = mpc + 16'd1;
                end
                z80_pkg::op_ld_b_n: begin
                    exp_b = opnd;
                    mpc   = mpc + 16'd1;
                end
                z80_pkg::op_ex_af: begin
                    tmp   = exp_a;
                    exp_a = a_alt;
                    a_alt = tmp;
                    tmp   = exp_f;
                    exp_f = f_alt;
                    f_alt = tmp;
                end
                z80_pkg::op_jr: mpc = mpc + 16'd1 + {{8{opnd[7]}}, opnd};
                z80_pkg::op_djnz: begin
                    exp_b = exp_b - 8'd1;
                    if (exp_b != 8'd0)
                        mpc = mpc + 16'd1 + {{8{opnd[7]}}, opnd};
                    else
                        mpc = mpc + 16'd1;
                end
                default: ;
            endcase
            steps++;
        end
    endtask

    // ------------------------------------------------------------------
    // Loading, video monitor and rounds
    // ------------------------------------------------------------------

    task automatic load_range(input int start, input int len);
        for (int i = start; i < start + len; i++) begin
            @(negedge clk_z80);
            load_en   = 1'b1;
            load_addr = i[mem_aw-1:0];
            load_data = img[i];
        end
        @(negedge clk_z80);
        load_en = 1'b0;
    endtask

    // Each pulse carries the next byte of the wrapping display sequence
    always @(negedge clk_z80) begin
        if (video_valid) begin
            check_value(video_data, img[video_base + vid_idx], "video byte");
            vid_idx = (vid_idx + 1) % video_len;
        end
    end

    task automatic run_round();
        @(negedge clk_z80);
        rst_n    = 1'b0;
        video_en = 1'b0;
        build_program();
        run_model();
        load_range(0, 256);                              // Program area
        load_range(video_base, video_len);               // Display region
        repeat (5) @(negedge clk_z80);
        vid_idx = 0;                                     // Video restarts at base
        check_value(pc, 16'h0000, "reset pc");
        check_value(reg_a, 8'h01, "reset A");
        check_value(reg_f, 8'h05, "reset F");
        check_value(reg_b, 8'h00, "reset B");
        check_value(iff1, 1'b0, "reset iff1");
        check_value(halted, 1'b0, "reset halted");
        check_value(video_valid, 1'b0, "reset video_valid");
        rst_n = 1'b1;
        while (!halted) begin
            if ($unsigned($random(seed)) % 8 == 0)
                video_en = ~video_en;                    // Bursts of stalls
            @(negedge clk_z80);
        end
        video_en = 1'b0;
        check_value(reg_a, exp_a, "final A");
        check_value(reg_f, exp_f, "final F");
        check_value(reg_b, exp_b, "final B");
        check_value(pc, halt_addr + 16'd1, "final pc");
        check_value(iff1, exp_iff1, "final iff1");
    endtask

    initial begin
        seed      = 32'h5c20;
        vid_idx   = 0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = 8'h00;
        video_en  = 1'b0;
        repeat (n_rounds) run_round();
        $display("Result: PASSED");
        $finish;
    end

    initial begin                                        // Watchdog
        #(n_rounds * 2000 * clk_period);
        $display("Timeout: the DUT did not reach HALT within the time limit");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== hw/z80_system.sv ====
`timescale 1ns/1ps

module z80_system #(
    parameter int             mem_aw       = 10,
    parameter z80_pkg::addr_t video_base   = 16'h0300,
    parameter int             video_len    = 32,
    parameter int             video_period = 5,
    parameter z80_pkg::addr_t sp_init      = 16'hdff0
) (
    input  logic               clk_z80,
    input  logic               rst_n,
    input  logic               load_en,       // Only used during reset
    input  logic [mem_aw-1:0]  load_addr,
    input  z80_pkg::byte_t     load_data,
    input  logic               video_en,
    output z80_pkg::byte_t     reg_a,
    output z80_pkg::byte_t     reg_f,
    output z80_pkg::byte_t     reg_b,
    output z80_pkg::addr_t     pc,
    output logic               iff1,
    output logic               halted,
    output z80_pkg::byte_t     video_data,
    output logic               video_valid
);

    z80_pkg::addr_t     core_addr;
    z80_pkg::addr_t     video_addr;
    logic               video_req;
    logic               core_wait;
    logic [mem_aw-1:0]  mem_addr;
    z80_pkg::byte_t     rd_data;          // Seen by both masters

    // ----------------------------------------------------------------------
    // Masters
    // ----------------------------------------------------------------------

    z80_core #(.sp_init(sp_init)) z80_core_inst (
        .clk_z80(clk_z80), .rst_n(rst_n), .i_data(rd_data), .core_wait(core_wait),
        .addr(core_addr), .reg_a(reg_a), .reg_f(reg_f), .reg_b(reg_b),
        .pc(pc), .iff1(iff1), .halted(halted)
    );

    video_fetch #(
        .video_base(video_base), .video_len(video_len), .video_period(video_period)
    ) video_fetch_inst (
        .clk_z80(clk_z80), .rst_n(rst_n), .video_en(video_en), .i_data(rd_data),
        .video_req(video_req), .video_addr(video_addr),
        .video_data(video_data), .video_valid(video_valid)
    );

    // ----------------------------------------------------------------------
    // Arbitration and memory
    // ----------------------------------------------------------------------

    mem_arbiter #(.mem_aw(mem_aw)) mem_arbiter_inst (
        .video_req(video_req), .video_addr(video_addr), .core_addr(core_addr),
        .mem_addr(mem_addr), .core_wait(core_wait)
    );

    shared_ram #(.mem_aw(mem_aw)) shared_ram_inst (
        .clk_z80(clk_z80), .wr_en(load_en), .wr_addr(load_addr), .wr_data(load_data),
        .rd_addr(mem_addr), .rd_data(rd_data)
    );

endmodule

// ==== hw/z80_core.sv ====
`timescale 1ns/1ps

module z80_core #(
    parameter z80_pkg::addr_t sp_init = 16'hdff0
) (
    input  logic             clk_z80,
    input  logic             rst_n,
    input  z80_pkg::byte_t   i_data,      // Memory read data
    input  logic             core_wait,   // Video owns memory, freeze
    output z80_pkg::addr_t   addr,
    output z80_pkg::byte_t   reg_a,
    output z80_pkg::byte_t   reg_f,
    output z80_pkg::byte_t   reg_b,
    output z80_pkg::addr_t   pc,
    output logic             iff1,
    output logic             halted
);

    // ----------------------------------------------------------------------
    // Register file
    // ----------------------------------------------------------------------

    z80_pkg::byte_t reg_c, reg_d, reg_e;  // Held only, no instruction uses them
    z80_pkg::byte_t reg_h, reg_l;

    // Alternate bank
    z80_pkg::byte_t a_prime, f_prime;
    z80_pkg::byte_t b_prime, c_prime, d_prime, e_prime, h_prime, l_prime;

    // Control registers
    z80_pkg::byte_t i_reg;                // Interrupt vector base
    z80_pkg::byte_t r_reg;                // Refresh, low 7 bits count
    z80_pkg::addr_t sp;
    logic           iff2;

    // DI/EI delay pipe
    logic pend_di, pend_ei;               // Set by the decode of DI/EI
    logic delay_di, delay_ei;             // Applied at the second fetch

    // Sequencing
    z80_pkg::m_state_t m_state;
    z80_pkg::t_count_t t_state;           // Padding cycles still to burn
    z80_pkg::byte_t    opcode;            // Latched at fetch

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    logic [6:0]     r_inc;
    z80_pkg::addr_t rel16;                // Sign-extended displacement

    assign r_inc  = r_reg[6:0] + 7'd1;
    assign rel16  = {{8{i_data[7]}}, i_data};

    assign addr   = pc;                   // Core only ever reads at PC
    assign halted = (m_state == z80_pkg::m_halt);

    // ----------------------------------------------------------------------
    // Fetch / decode / execute
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_z80) begin
        if (!rst_n) begin
            reg_a    <= 8'h01;
            reg_f    <= 8'h05;
            reg_b    <= 8'h00;
            reg_c    <= 8'h00;
            reg_d    <= 8'h00;
            reg_e    <= 8'h00;
            reg_h    <= 8'h00;
            reg_l    <= 8'h00;
            a_prime  <= 8'h02;
            f_prime  <= 8'h04;
            b_prime  <= 8'h00;
            c_prime  <= 8'h00;
            d_prime  <= 8'h00;
            e_prime  <= 8'h00;
            h_prime  <= 8'h00;
            l_prime  <= 8'h00;
            i_reg    <= 8'h00;
            r_reg    <= 8'h00;
            sp       <= sp_init;
            pc       <= 16'h0000;
            iff1     <= 1'b0;
            iff2     <= 1'b0;
            pend_di  <= 1'b0;
            pend_ei  <= 1'b0;
            delay_di <= 1'b0;
            delay_ei <= 1'b0;
            m_state  <= z80_pkg::m_fetch;
            t_state  <= 4'd0;
            opcode   <= z80_pkg::op_nop;
        end else if (!core_wait) begin          // Frozen while video reads
            if (t_state != 4'd0) begin
                t_state <= t_state - 4'd1;      // Pad to documented length
            end else begin
                case (m_state)
                    z80_pkg::m_fetch: begin
                        opcode <= i_data;
                        pc     <= pc + 16'd1;
                        r_reg  <= {r_reg[7], r_inc};   // Bit 7 kept

                        // Second fetch after DI/EI
                        if (delay_di) begin
                            iff1 <= 1'b0;
                            iff2 <= 1'b0;
                        end else if (delay_ei) begin
                            iff1 <= 1'b1;
                            iff2 <= 1'b1;
                        end
                        delay_di <= pend_di;    // Move one stage on
                        delay_ei <= pend_ei;
                        pend_di  <= 1'b0;
                        pend_ei  <= 1'b0;
                        m_state  <= z80_pkg::m_exec;
                    end

                    z80_pkg::m_exec: begin
                        m_state <= z80_pkg::m_fetch;
                        t_state <= 4'd2;        // 4T default
                        case (opcode)
                            z80_pkg::op_ex_af: begin
                                reg_a   <= a_prime;
                                reg_f   <= f_prime;
                                a_prime <= reg_a;
                                f_prime <= reg_f;
                            end

                            z80_pkg::op_djnz: begin
                                reg_b <= reg_b - 8'd1;
                                if (reg_b == 8'd1) begin
                                    t_state <= 4'd6;             // 8T, falls through
                                    pc      <= pc + 16'd1;
                                end else begin
                                    t_state <= 4'd11;            // 13T, taken
                                    pc      <= pc + 16'd1 + rel16;
                                end
                            end

                            z80_pkg::op_jr: begin
                                t_state <= 4'd10;                // 12T
                                pc      <= pc + 16'd1 + rel16;
                            end

                            z80_pkg::op_ld_b_n: begin
                                reg_b   <= i_data;               // Operand at PC
                                t_state <= 4'd5;                 // 7T
                                pc      <= pc + 16'd1;
                            end

                            z80_pkg::op_ld_a_n: begin
                                reg_a   <= i_data;
                                t_state <= 4'd5;
                                pc      <= pc + 16'd1;
                            end

                            z80_pkg::op_di: pend_di <= 1'b1;
                            z80_pkg::op_ei: pend_ei <= 1'b1;

                            z80_pkg::op_halt: begin
                                m_state <= z80_pkg::m_halt;      // Stop for good
                                t_state <= 4'd0;
                            end

                            default: ;                           // NOP and unknown
                        endcase
                    end

                    default: m_state <= z80_pkg::m_halt;        // Hold after HALT
                endcase
            end
        end
    end

endmodule

// ==== hw/video_fetch.sv ====
`timescale 1ns/1ps

module video_fetch #(
    parameter z80_pkg::addr_t video_base   = 16'h0300,
    parameter int             video_len    = 32,
    parameter int             video_period = 5      // At least 2
) (
    input  logic             clk_z80,
    input  logic             rst_n,
    input  logic             video_en,
    input  z80_pkg::byte_t   i_data,
    output logic             video_req,
    output z80_pkg::addr_t   video_addr,
    output z80_pkg::byte_t   video_data,
    output logic             video_valid
);

    localparam int cnt_w = (video_period > 1) ? $clog2(video_period) : 1;
    localparam int ofs_w = (video_len > 1) ? $clog2(video_len) : 1;

    logic [cnt_w-1:0] interval;           // Cycles since last read
    logic [ofs_w-1:0] ofs;                // Position inside display region

    // Read in the last cycle of each interval
    assign video_req  = video_en && (interval == cnt_w'(video_period - 1));
    assign video_addr = video_base + z80_pkg::addr_t'(ofs);

    always_ff @(posedge clk_z80) begin
        if (!rst_n) begin
            interval    <= '0;
            ofs         <= '0;
            video_valid <= 1'b0;
        end else begin
            video_valid <= video_req;       // One cycle behind the read
            if (video_en) begin             // Paused otherwise, address kept
                if (video_req) begin
                    interval <= '0;
                    if (ofs == ofs_w'(video_len - 1))
                        ofs <= '0;          // Wrap to video_base
                    else
                        ofs <= ofs + ofs_w'(1);
                end else begin
                    interval <= interval + cnt_w'(1);
                end
            end
        end
    end

    // Byte captured in the read cycle
    always_ff @(posedge clk_z80) begin
        if (video_req)
            video_data <= i_data;
    end

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int mem_aw = 10
) (
    input  logic               video_req,
    input  z80_pkg::addr_t     video_addr,
    input  z80_pkg::addr_t     core_addr,
    output logic [mem_aw-1:0]  mem_addr,
    output logic               core_wait
);

    // ----------------------------------------------------------------------
    // Fixed priority, video first
    // ----------------------------------------------------------------------

    z80_pkg::addr_t sel_addr;               // Full-width winner

    always_comb begin
        if (video_req)
            sel_addr = video_addr;          // Video never waits
        else
            sel_addr = core_addr;
    end

    // Upper address bits fall away
    assign mem_addr  = sel_addr[mem_aw-1:0];

    // Core holds every register while video owns the bus
    assign core_wait = video_req;

endmodule

// ==== hw/shared_ram.sv ====
`timescale 1ns/1ps

module shared_ram #(
    parameter int mem_aw = 10
) (
    input  logic               clk_z80,
    input  logic               wr_en,      // Load port
    input  logic [mem_aw-1:0]  wr_addr,
    input  z80_pkg::byte_t     wr_data,
    input  logic [mem_aw-1:0]  rd_addr,
    output z80_pkg::byte_t     rd_data
);

    localparam int depth = 2 ** mem_aw;

    z80_pkg::byte_t mem [depth];           // Contents survive reset

    // ----------------------------------------------------------------------
    // Synchronous write
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_z80) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // ----------------------------------------------------------------------
    // Asynchronous read, same cycle data
    // ----------------------------------------------------------------------

    assign rd_data = mem[rd_addr];

endmodule

// ==== hw/z80_pkg.sv ====
package z80_pkg;

    // ----------------------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------------------

    typedef logic [7:0]  byte_t;      // Data byte or 8-bit register
    typedef logic [15:0] addr_t;      // Memory address or PC
    typedef logic [3:0]  t_count_t;   // Padding cycles left in an instruction

    // Core machine state
    typedef enum logic [1:0] {
        m_fetch,                      // Opcode read from PC
        m_exec,                       // Decode and execute
        m_halt                        // Stopped until reset
    } m_state_t;

    // ----------------------------------------------------------------------
    // Opcodes of the supported subset
    // ----------------------------------------------------------------------

    localparam byte_t op_nop    = 8'h00;
    localparam byte_t op_ld_b_n = 8'h06;
    localparam byte_t op_ex_af  = 8'h08;   // EX AF,AF'
    localparam byte_t op_djnz   = 8'h10;
    localparam byte_t op_jr     = 8'h18;
    localparam byte_t op_ld_a_n = 8'h3E;
    localparam byte_t op_halt   = 8'h76;
    localparam byte_t op_di     = 8'hF3;
    localparam byte_t op_ei     = 8'hFB;

endpackage
